// ==== noc_bridge_pkg.sv ====
package noc_bridge_pkg;

    typedef logic [63:0] noc_flit_t;
    typedef logic [31:0] axi_addr_t;
    typedef logic [47:0] msg_addr_t;
    typedef logic [13:0] chipid_t;
    typedef logic [7:0]  coord_t;
    typedef logic [3:0]  fbits_t;
    typedef logic [7:0]  msg_type_t;
    typedef logic [7:0]  msg_len_t;   // flits after the first header
    typedef logic [1:0]  axi_resp_t;

    localparam int noc_flit_bits = 64;

    localparam msg_type_t msg_nc_load_req  = 8'd14;
    localparam msg_type_t msg_nc_store_req = 8'd15;
    localparam msg_type_t msg_nc_load_resp = 8'd24;
    localparam msg_type_t msg_nc_store_ack = 8'd25;

    localparam logic [2:0] data_size_64b = 3'd6;

    localparam axi_resp_t axi_resp_okay   = 2'b00;
    localparam axi_resp_t axi_resp_slverr = 2'b10;

    // header flit 1, also used for response headers
    localparam int hdr_dst_chip_msb = 63;
    localparam int hdr_dst_chip_lsb = 50;
    localparam int hdr_dst_x_msb    = 49;
    localparam int hdr_dst_x_lsb    = 42;
    localparam int hdr_dst_y_msb    = 41;
    localparam int hdr_dst_y_lsb    = 34;
    localparam int hdr_dst_fbits_msb = 33;
    localparam int hdr_dst_fbits_lsb = 30;
    localparam int hdr_len_msb      = 29;
    localparam int hdr_len_lsb      = 22;
    localparam int hdr_type_msb     = 21;
    localparam int hdr_type_lsb     = 14;

    // header flit 2
    localparam int hdr_addr_msb     = 63;
    localparam int hdr_addr_lsb     = 16;
    localparam int hdr_size_msb     = 15;
    localparam int hdr_size_lsb     = 13;

    // header flit 3 reuses the chip/x/y/fbits positions for the source

    typedef enum logic [1:0] {
        bld_idle,
        bld_header,
        bld_data
    } builder_state_t;

    typedef enum logic {
        rsp_header,
        rsp_data
    } resp_state_t;

endpackage

// ==== sync_fifo.sv ====
module sync_fifo #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             full,
    output logic             empty
);
    localparam int depth = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]    mem [depth];
    logic [DEPTH_LOG2:0] wr_ptr;   // extra msb tells full from empty
    logic [DEPTH_LOG2:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr[DEPTH_LOG2-1:0]] <= push_data;
    end

    assign pop_data = mem[rd_ptr[DEPTH_LOG2-1:0]];   // head shown without delay
    assign empty    = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                      (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(push && full));
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(pop && empty));

endmodule

// ==== axi_request_queue.sv ====
module axi_request_queue #(
    parameter int AXI_DATA_WIDTH  = 128,
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  noc_bridge_pkg::axi_addr_t awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [AXI_DATA_WIDTH-1:0] wdata,
    input  logic                      wvalid,
    output logic                      wready,
    input  noc_bridge_pkg::axi_addr_t araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic                      req_valid,
    output logic                      req_store,
    output noc_bridge_pkg::axi_addr_t req_addr,
    output logic [AXI_DATA_WIDTH-1:0] req_wdata,
    input  logic                      req_pop
);
    import noc_bridge_pkg::*;

    logic      order_full;
    logic      order_empty;
    logic      waddr_full;
    logic      waddr_empty;
    logic      wdata_full;
    logic      wdata_empty;
    logic      raddr_full;
    logic      raddr_empty;
    logic      store_acc;
    logic      load_acc;
    axi_addr_t waddr_head;
    axi_addr_t raddr_head;

    assign awready = !order_full && !waddr_full;
    assign wready  = !order_full && !wdata_full;
    // store needs address and data in the same cycle
    assign store_acc = awvalid && wvalid && awready && wready;
    assign arready   = !order_full && !raddr_full && !store_acc;   // stores win the slot
    assign load_acc  = arvalid && arready;

    assign req_valid = !order_empty &&
                       (req_store ? (!waddr_empty && !wdata_empty) : !raddr_empty);
    assign req_addr  = req_store ? waddr_head : raddr_head;

    // 1 = store, 0 = load
    sync_fifo #(.WIDTH(1), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) order_fifo (
        .clk(clk), .rst(rst),
        .push(store_acc || load_acc), .push_data(store_acc),
        .pop(req_pop), .pop_data(req_store),
        .full(order_full), .empty(order_empty)
    );

    sync_fifo #(.WIDTH($bits(axi_addr_t)), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) waddr_fifo (
        .clk(clk), .rst(rst),
        .push(store_acc), .push_data(awaddr),
        .pop(req_pop && req_store), .pop_data(waddr_head),
        .full(waddr_full), .empty(waddr_empty)
    );

    sync_fifo #(.WIDTH(AXI_DATA_WIDTH), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) wdata_fifo (
        .clk(clk), .rst(rst),
        .push(store_acc), .push_data(wdata),
        .pop(req_pop && req_store), .pop_data(req_wdata),
        .full(wdata_full), .empty(wdata_empty)
    );

    sync_fifo #(.WIDTH($bits(axi_addr_t)), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) raddr_fifo (
        .clk(clk), .rst(rst),
        .push(load_acc), .push_data(araddr),
        .pop(req_pop && !req_store), .pop_data(raddr_head),
        .full(raddr_full), .empty(raddr_empty)
    );

    // address and data FIFOs must stay in lockstep
    a_aw_w_ready: assert property (@(posedge clk) disable iff (rst) awready == wready);

endmodule

// ==== request_flit_builder.sv ====
module request_flit_builder #(
    parameter int AXI_DATA_WIDTH = 128
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    input  logic                      req_store,
    input  noc_bridge_pkg::axi_addr_t req_addr,
    input  logic [AXI_DATA_WIDTH-1:0] req_wdata,
    output logic                      req_pop,
    input  noc_bridge_pkg::chipid_t   src_chipid,
    input  noc_bridge_pkg::coord_t    src_x,
    input  noc_bridge_pkg::coord_t    src_y,
    input  noc_bridge_pkg::fbits_t    src_fbits,
    input  noc_bridge_pkg::chipid_t   dest_chipid,
    input  noc_bridge_pkg::coord_t    dest_x,
    input  noc_bridge_pkg::coord_t    dest_y,
    input  noc_bridge_pkg::fbits_t    dest_fbits,
    output logic                      noc2_valid,
    output noc_bridge_pkg::noc_flit_t noc2_data,
    input  logic                      noc2_ready
);
    import noc_bridge_pkg::*;

    localparam int payload_flits = AXI_DATA_WIDTH / noc_flit_bits;

    builder_state_t state;
    msg_len_t       cnt;        // flit index inside the current section
    msg_len_t       msg_len;
    msg_type_t      msg_type;
    logic           flit_done;
    logic           last_flit;

    assign msg_len   = req_store ? msg_len_t'(2 + payload_flits) : msg_len_t'(2);
    assign msg_type  = req_store ? msg_nc_store_req : msg_nc_load_req;
    assign flit_done = noc2_valid && noc2_ready;
    assign last_flit = (state == bld_header && cnt == msg_len_t'(2) && !req_store) ||
                       (state == bld_data && cnt == msg_len_t'(payload_flits - 1));
    assign req_pop    = flit_done && last_flit;
    assign noc2_valid = (state != bld_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= bld_idle;
            cnt   <= '0;
        end else begin
            case (state)
                bld_idle: begin
                    if (req_valid) begin
                        state <= bld_header;
                        cnt   <= '0;
                    end
                end
                bld_header: begin
                    if (flit_done) begin
                        if (cnt == msg_len_t'(2)) begin
                            cnt   <= '0;
                            state <= req_store ? bld_data : bld_idle;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                bld_data: begin
                    if (flit_done) begin
                        if (last_flit) begin
                            state <= bld_idle;
                            cnt   <= '0;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                default: state <= bld_idle;
            endcase
        end
    end

    // flit mux, all inputs hold while the head request is pending
    always_comb begin
        noc2_data = '0;
        case (state)
            bld_header: begin
                case (cnt)
                    8'd0: begin
                        noc2_data[hdr_dst_chip_msb:hdr_dst_chip_lsb]   = dest_chipid;
                        noc2_data[hdr_dst_x_msb:hdr_dst_x_lsb]         = dest_x;
                        noc2_data[hdr_dst_y_msb:hdr_dst_y_lsb]         = dest_y;
                        noc2_data[hdr_dst_fbits_msb:hdr_dst_fbits_lsb] = dest_fbits;
                        noc2_data[hdr_len_msb:hdr_len_lsb]             = msg_len;
                        noc2_data[hdr_type_msb:hdr_type_lsb]           = msg_type;
                    end
                    8'd1: begin
                        noc2_data[hdr_addr_msb:hdr_addr_lsb] = msg_addr_t'(req_addr);
                        noc2_data[hdr_size_msb:hdr_size_lsb] = data_size_64b;
                    end
                    default: begin
                        noc2_data[hdr_dst_chip_msb:hdr_dst_chip_lsb]   = src_chipid;
                        noc2_data[hdr_dst_x_msb:hdr_dst_x_lsb]         = src_x;
                        noc2_data[hdr_dst_y_msb:hdr_dst_y_lsb]         = src_y;
                        noc2_data[hdr_dst_fbits_msb:hdr_dst_fbits_lsb] = src_fbits;
                    end
                endcase
            end
            bld_data: noc2_data = req_wdata[cnt*noc_flit_bits +: noc_flit_bits];  // low half first
            default: noc2_data = '0;
        endcase
    end

    a_flit_hold: assert property (@(posedge clk) disable iff (rst)
        noc2_valid && !noc2_ready |=> noc2_valid && $stable(noc2_data));

endmodule

// ==== response_assembler.sv ====
module response_assembler #(
    parameter int AXI_DATA_WIDTH = 128
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      noc3_valid,
    input  noc_bridge_pkg::noc_flit_t noc3_data,
    output logic                      noc3_ready,
    output logic [AXI_DATA_WIDTH-1:0] rdata,
    output noc_bridge_pkg::axi_resp_t rresp,
    output logic                      rvalid,
    input  logic                      rready,
    output noc_bridge_pkg::axi_resp_t bresp,
    output logic                      bvalid,
    input  logic                      bready
);
    import noc_bridge_pkg::*;

    localparam int payload_flits = AXI_DATA_WIDTH / noc_flit_bits;

    resp_state_t state;
    msg_len_t    beat;       // payload flit index
    msg_len_t    len_q;
    logic        to_read;    // finishes on the r channel
    logic        err;
    logic        flit_in;
    logic        last_beat;
    msg_type_t   hdr_type;
    msg_len_t    hdr_len;
    logic        hdr_to_read;
    logic        hdr_err;

    assign noc3_ready = !rvalid && !bvalid;   // stall while a response waits
    assign flit_in    = noc3_valid && noc3_ready;
    assign last_beat  = (beat == len_q - 1'b1);
    assign hdr_type   = noc3_data[hdr_type_msb:hdr_type_lsb];
    assign hdr_len    = noc3_data[hdr_len_msb:hdr_len_lsb];
    // unknown types with payload go to r, without payload to b
    assign hdr_to_read = (hdr_type == msg_nc_load_resp) ||
                         (hdr_type != msg_nc_store_ack && hdr_len != '0);
    assign hdr_err = !((hdr_type == msg_nc_load_resp) ||
                       (hdr_type == msg_nc_store_ack && hdr_len == '0));

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= rsp_header;
            beat   <= '0;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (rvalid && rready) rvalid <= 1'b0;
            if (bvalid && bready) bvalid <= 1'b0;
            if (flit_in) begin
                if (state == rsp_header) begin
                    if (hdr_len == '0) begin
                        rvalid <= hdr_to_read;
                        bvalid <= !hdr_to_read;
                    end else begin
                        state <= rsp_data;
                        beat  <= '0;
                    end
                end else if (last_beat) begin
                    state  <= rsp_header;
                    rvalid <= to_read;
                    bvalid <= !to_read;
                end else begin
                    beat <= beat + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flit_in) begin
            if (state == rsp_header) begin
                len_q   <= hdr_len;
                to_read <= hdr_to_read;
                err     <= hdr_err;
                if (hdr_to_read) rdata <= '0;
                rresp <= hdr_err ? axi_resp_slverr : axi_resp_okay;
                bresp <= hdr_err ? axi_resp_slverr : axi_resp_okay;
            end else begin
                if (to_read && beat < msg_len_t'(payload_flits)) begin
                    rdata[beat*noc_flit_bits +: noc_flit_bits] <= noc3_data;   // low part first
                end
                rresp <= err ? axi_resp_slverr : axi_resp_okay;
                bresp <= err ? axi_resp_slverr : axi_resp_okay;
            end
        end
    end

endmodule

// ==== axilite_noc_bridge.sv ====
module axilite_noc_bridge #(
    parameter int AXI_DATA_WIDTH  = 128,
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    output logic                      noc2_valid_out,
    output noc_bridge_pkg::noc_flit_t noc2_data_out,
    input  logic                      noc2_ready_in,
    input  logic                      noc3_valid_in,
    input  noc_bridge_pkg::noc_flit_t noc3_data_in,
    output logic                      noc3_ready_out,
    input  noc_bridge_pkg::chipid_t   src_chipid,
    input  noc_bridge_pkg::coord_t    src_x,
    input  noc_bridge_pkg::coord_t    src_y,
    input  noc_bridge_pkg::fbits_t    src_fbits,
    input  noc_bridge_pkg::chipid_t   dest_chipid,
    input  noc_bridge_pkg::coord_t    dest_x,
    input  noc_bridge_pkg::coord_t    dest_y,
    input  noc_bridge_pkg::fbits_t    dest_fbits,
    input  noc_bridge_pkg::axi_addr_t awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [AXI_DATA_WIDTH-1:0] wdata,
    input  logic                      wvalid,
    output logic                      wready,
    input  noc_bridge_pkg::axi_addr_t araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [AXI_DATA_WIDTH-1:0] rdata,
    output noc_bridge_pkg::axi_resp_t rresp,
    output logic                      rvalid,
    input  logic                      rready,
    output noc_bridge_pkg::axi_resp_t bresp,
    output logic                      bvalid,
    input  logic                      bready
);
    logic                      req_valid;
    logic                      req_store;
    noc_bridge_pkg::axi_addr_t req_addr;
    logic [AXI_DATA_WIDTH-1:0] req_wdata;
    logic                      req_pop;

    axi_request_queue #(
        .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) u_queue (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .req_valid(req_valid), .req_store(req_store), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_pop(req_pop)
    );

    request_flit_builder #(.AXI_DATA_WIDTH(AXI_DATA_WIDTH)) u_builder (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_store(req_store), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_pop(req_pop),
        .src_chipid(src_chipid), .src_x(src_x), .src_y(src_y), .src_fbits(src_fbits),
        .dest_chipid(dest_chipid), .dest_x(dest_x), .dest_y(dest_y), .dest_fbits(dest_fbits),
        .noc2_valid(noc2_valid_out), .noc2_data(noc2_data_out), .noc2_ready(noc2_ready_in)
    );

    response_assembler #(.AXI_DATA_WIDTH(AXI_DATA_WIDTH)) u_resp (
        .clk(clk), .rst(rst),
        .noc3_valid(noc3_valid_in), .noc3_data(noc3_data_in), .noc3_ready(noc3_ready_out),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready)
    );

endmodule

// ==== tb_axilite_noc_bridge.sv ====
module tb_axilite_noc_bridge;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period  = 8;
    localparam int watchdog_ns = 2500 * clk_period;   // six tests of well under 400 cycles each

    logic         clk;
    logic         rst;
    logic         noc2_valid_out;
    logic [63:0]  noc2_data_out;
    logic         noc2_ready_in;
    logic         noc3_valid_in;
    logic [63:0]  noc3_data_in;
    logic         noc3_ready_out;
    logic [13:0]  src_chipid;
    logic [7:0]   src_x;
    logic [7:0]   src_y;
    logic [3:0]   src_fbits;
    logic [13:0]  dest_chipid;
    logic [7:0]   dest_x;
    logic [7:0]   dest_y;
    logic [3:0]   dest_fbits;
    logic [31:0]  awaddr;
    logic         awvalid;
    logic         awready;
    logic [127:0] wdata;
    logic         wvalid;
    logic         wready;
    logic [31:0]  araddr;
    logic         arvalid;
    logic         arready;
    logic [127:0] rdata;
    logic [1:0]   rresp;
    logic         rvalid;
    logic         rready;
    logic [1:0]   bresp;
    logic         bvalid;
    logic         bready;

    logic [63:0]  exp_flits[$];          // every flit expected on noc2 in order
    logic [127:0] exp_rdata[$];
    logic         exp_rdata_known[$];
    logic [1:0]   exp_rresp[$];
    logic [1:0]   exp_bresp[$];
    logic [63:0]  resp_flits[$];         // memory side, waiting to go out on noc3
    logic [127:0] ref_mem[logic [31:0]];  // last value issued per address
    logic [127:0] resp_mem[logic [31:0]]; // memory-side contents
    logic [63:0]  held_flit;
    bit           stalled;
    bit           random_ready;
    bit           bad_type;              // memory side answers with an unknown type
    bit           reset_done;
    int           errors;
    int           errors_at_start;
    int           tests_run;
    int           tests_failed;

    axilite_noc_bridge #(.AXI_DATA_WIDTH(128), .FIFO_DEPTH_LOG2(4)) dut (
        .clk(clk), .rst(rst),
        .noc2_valid_out(noc2_valid_out), .noc2_data_out(noc2_data_out),
        .noc2_ready_in(noc2_ready_in),
        .noc3_valid_in(noc3_valid_in), .noc3_data_in(noc3_data_in),
        .noc3_ready_out(noc3_ready_out),
        .src_chipid(src_chipid), .src_x(src_x), .src_y(src_y), .src_fbits(src_fbits),
        .dest_chipid(dest_chipid), .dest_x(dest_x), .dest_y(dest_y), .dest_fbits(dest_fbits),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: run did not finish within %0d ns", watchdog_ns);
        $display("** FAIL **");
        $finish;
    end

    // unwritten memory reads back a pattern built from the whole address
    function automatic logic [127:0] fill_value(input logic [31:0] addr);
        return {addr ^ 32'hdead_beef, ~addr, addr + 32'h1234_5678, addr};
    endfunction

    function automatic logic [127:0] rand128();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    task automatic value_error(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        $display("FAILED %s: got %h, expected %h", name, got, exp);
        errors++;
    endtask

    task automatic event_error(input string what);
        $display("error: %s", what);
        errors++;
    endtask

    // expected noc2 message and AXI response for one accepted request
    task automatic push_expected(input bit store, input logic [31:0] addr,
                                 input logic [127:0] data);
        logic [7:0] len;
        logic [7:0] mtype;
        len   = store ? 8'd4 : 8'd2;
        mtype = store ? 8'd15 : 8'd14;
        exp_flits.push_back({dest_chipid, dest_x, dest_y, dest_fbits, len, mtype, 14'h0});
        exp_flits.push_back({16'h0, addr, 3'd6, 13'h0});
        exp_flits.push_back({src_chipid, src_x, src_y, src_fbits, 30'h0});
        if (store) begin
            exp_flits.push_back(data[63:0]);
            exp_flits.push_back(data[127:64]);
            exp_bresp.push_back(bad_type ? 2'd2 : 2'd0);
            ref_mem[addr] = data;
        end else begin
            exp_rdata.push_back(ref_mem.exists(addr) ? ref_mem[addr] : fill_value(addr));
            exp_rdata_known.push_back(!bad_type);
            exp_rresp.push_back(bad_type ? 2'd2 : 2'd0);
        end
    endtask

    task automatic issue_store(input logic [31:0] addr, input logic [127:0] data);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(posedge clk); while (!(awready && wready));
        push_expected(1'b1, addr, data);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic issue_load(input logic [31:0] addr);
        araddr  = addr;
        arvalid = 1'b1;
        do @(posedge clk); while (!arready);
        push_expected(1'b0, addr, '0);
        #1;
        arvalid = 1'b0;
    endtask

    // loads only go to addresses that already hold a value
    task automatic random_op();
        logic [31:0] addr;
        addr = 32'h8000_1000 | (32'($urandom_range(3)) << 6);
        if (ref_mem.exists(addr) && $urandom_range(1) == 1) issue_load(addr);
        else issue_store(addr, rand128());
    endtask

    task automatic wait_drain();
        while (exp_flits.size() != 0 || exp_rresp.size() != 0 || exp_bresp.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic end_test(input int num, input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d check(s) failed", num, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic take_flit(output logic [63:0] flit);
        do @(posedge clk); while (!(noc2_valid_out && noc2_ready_in));
        flit = noc2_data_out;
    endtask

    // noc2 flit order and stall hold
    always @(posedge clk) begin
        if (rst) begin
            stalled = 1'b0;
        end else begin
            if (stalled) begin
                assert (noc2_valid_out) else event_error("noc2_valid_out dropped during a stall");
                assert (noc2_data_out == held_flit)
                    else value_error("noc2_data_out", 128'(noc2_data_out), 128'(held_flit));
            end
            if (noc2_valid_out && noc2_ready_in) begin
                if (exp_flits.size() == 0) event_error("flit on noc2 with no request pending");
                else begin
                    held_flit = exp_flits.pop_front();
                    assert (noc2_data_out == held_flit)
                        else value_error("noc2_data_out", 128'(noc2_data_out), 128'(held_flit));
                end
            end
            stalled   = noc2_valid_out && !noc2_ready_in;
            held_flit = noc2_data_out;
        end
    end

    always @(posedge clk) begin : response_check
        logic [127:0] exp_d;
        logic         known;
        logic [1:0]   exp_resp;
        if (!rst && rvalid && rready) begin
            if (exp_rresp.size() == 0) event_error("read response with no load outstanding");
            else begin
                exp_d    = exp_rdata.pop_front();
                known    = exp_rdata_known.pop_front();
                exp_resp = exp_rresp.pop_front();
                assert (rresp == exp_resp) else value_error("rresp", 128'(rresp), 128'(exp_resp));
                assert (!known || rdata == exp_d) else value_error("rdata", rdata, exp_d);
            end
        end
        if (!rst && bvalid && bready) begin
            if (exp_bresp.size() == 0) event_error("write response with no store outstanding");
            else begin
                exp_resp = exp_bresp.pop_front();
                assert (bresp == exp_resp) else value_error("bresp", 128'(bresp), 128'(exp_resp));
            end
        end
    end

    // memory side that collects noc2 messages and queues the answers
    initial begin : noc2_collector
        logic [63:0]  h1;
        logic [63:0]  h2;
        logic [63:0]  h3;
        logic [63:0]  lo;
        logic [63:0]  hi;
        logic [31:0]  addr;
        logic [127:0] data;
        logic [7:0]   rtype;
        wait (reset_done);
        forever begin
            take_flit(h1);
            take_flit(h2);
            take_flit(h3);
            addr = h2[47:16];
            if (h1[21:14] == 8'd15) begin
                take_flit(lo);
                take_flit(hi);
                resp_mem[addr] = {hi, lo};
                rtype = bad_type ? 8'hee : 8'd25;
                resp_flits.push_back({34'h0, 8'd0, rtype, 14'h0});
            end else begin
                data  = resp_mem.exists(addr) ? resp_mem[addr] : fill_value(addr);
                rtype = bad_type ? 8'hee : 8'd24;
                resp_flits.push_back({34'h0, 8'd2, rtype, 14'h0});
                resp_flits.push_back(data[63:0]);
                resp_flits.push_back(data[127:64]);
            end
        end
    end

    initial begin : noc3_sender
        bit hold;
        wait (reset_done);
        forever begin
            @(posedge clk);
            hold = noc3_valid_in && !noc3_ready_out;
            if (noc3_valid_in && noc3_ready_out) void'(resp_flits.pop_front());
            #1;
            if (!hold) begin
                if (resp_flits.size() != 0 && $urandom_range(3) != 0) begin   // random gaps
                    noc3_valid_in = 1'b1;
                    noc3_data_in  = resp_flits[0];
                end else begin
                    noc3_valid_in = 1'b0;
                    noc3_data_in  = '0;
                end
            end
        end
    end

    initial begin : ready_driver
        wait (reset_done);
        forever begin
            @(posedge clk);
            #1;
            noc2_ready_in = random_ready ? 1'($urandom()) : 1'b1;
            rready        = random_ready ? 1'($urandom()) : 1'b1;
            bready        = random_ready ? 1'($urandom()) : 1'b1;
        end
    end

    initial begin
        void'($urandom(32'h3b9b75ed));
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        bready = 1'b1;
        noc2_ready_in = 1'b1;
        noc3_valid_in = 1'b0;
        noc3_data_in = '0;
        src_chipid = 14'h0a5;
        src_x = 8'h03;
        src_y = 8'h07;
        src_fbits = 4'h0;
        dest_chipid = 14'h1c2;
        dest_x = 8'h11;
        dest_y = 8'h22;
        dest_fbits = 4'h9;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_done = 1'b1;

        assert (!noc2_valid_out) else value_error("noc2_valid_out", 128'(noc2_valid_out), 0);
        assert (!rvalid) else value_error("rvalid", 128'(rvalid), 0);
        assert (!bvalid) else value_error("bvalid", 128'(bvalid), 0);
        assert (awready) else value_error("awready", 128'(awready), 1);
        assert (wready) else value_error("wready", 128'(wready), 1);
        assert (arready) else value_error("arready", 128'(arready), 1);
        assert (noc3_ready_out) else value_error("noc3_ready_out", 128'(noc3_ready_out), 1);
        end_test(1, "reset state");

        issue_store(32'h0000_2a40, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210);
        wait_drain();
        end_test(2, "single store");

        issue_load(32'h0000_2a40);
        wait_drain();
        end_test(3, "single load");

        random_ready = 1'b1;
        repeat (12) random_op();
        wait_drain();
        random_ready = 1'b0;
        end_test(4, "random noc2 backpressure");

        repeat (16) random_op();
        wait_drain();
        end_test(5, "mixed back to back");

        bad_type = 1'b1;
        issue_load(32'h0000_2a40);
        issue_store(32'h0000_2a80, rand128());
        wait_drain();
        bad_type = 1'b0;
        end_test(6, "unknown response type");

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
noc_bridge_pkg.sv
sync_fifo.sv
axi_request_queue.sv
request_flit_builder.sv
response_assembler.sv
axilite_noc_bridge.sv
tb_axilite_noc_bridge.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_axilite_noc_bridge -f tb.f -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
